//--- src.f
+incdir+test
design/mulDivPkg.sv
design/carrySelectAdder64.sv
design/mulDivOperandPrep.sv
design/mulDivIterator.sv
design/mulDivResultFix.sv
design/slowMulDiv.sv
test/slowMulDivTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert --timing --timescale 1ns/1ns \
	-f src.f --top-module slowMulDivTb -Mdir "$buildDir" -o slowMulDivTb
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$buildDir/slowMulDivTb" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$logFile"; then
	exit 0
fi
echo "pass message not found in $logFile"
exit 1

//--- test/mulDivVectors.svh
// flags: isDiv isUnsigned unsignedB is32 wantAlt bypass
// then valueA, valueB, expected resultLo, expected resultHi
function automatic void loadVectors();
	// 64-bit multiplies, full 128-bit product
	addVector("mul u small", 6'b010000, 64'h6, 64'h7, 64'h2a, 64'h0);
	addVector("mul u all ones", 6'b010000, 64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF,
		64'h1, 64'hFFFFFFFFFFFFFFFE);
	addVector("mul s neg*neg", 6'b000000, 64'hFFFFFFFFFFFFFFFD, 64'hFFFFFFFFFFFFFFF9,
		64'h15, 64'h0);
	addVector("mul s neg*pos", 6'b000000, 64'hFFFFFFFFFFFFFFFD, 64'h5,
		64'hFFFFFFFFFFFFFFF1, 64'hFFFFFFFFFFFFFFFF);
	// most negative operands
	addVector("mul s min*min", 6'b000000, 64'h8000000000000000, 64'h8000000000000000,
		64'h0, 64'h4000000000000000);
	addVector("mul s min*one", 6'b000000, 64'h8000000000000000, 64'h1,
		64'h8000000000000000, 64'hFFFFFFFFFFFFFFFF);
	// B all ones read as 2^64-1, not -1
	addVector("mul su neg*big", 6'b001000, 64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF,
		64'h1, 64'hFFFFFFFFFFFFFFFF);
	// quotient truncates toward zero, remainder takes the dividend sign
	addVector("div s pos/pos", 6'b100000, 64'h64, 64'h7, 64'he, 64'h2);
	addVector("div s neg/pos", 6'b100000, 64'hFFFFFFFFFFFFFF9C, 64'h7,
		64'hFFFFFFFFFFFFFFF2, 64'hFFFFFFFFFFFFFFFE);
	addVector("div s pos/neg alt", 6'b100010, 64'h64, 64'hFFFFFFFFFFFFFFF9,
		64'h2, 64'hFFFFFFFFFFFFFFF2);
	addVector("div s neg/neg", 6'b100000, 64'hFFFFFFFFFFFFFF9C, 64'hFFFFFFFFFFFFFFF9,
		64'he, 64'hFFFFFFFFFFFFFFFE);
	addVector("div s min/two", 6'b100000, 64'h8000000000000000, 64'h2,
		64'hC000000000000000, 64'h0);
	addVector("div u big", 6'b110000, 64'hFFFFFFFFFFFFFFFF, 64'h10,
		64'h0FFFFFFFFFFFFFFF, 64'hf);
	// all ones quotient, dividend comes back as remainder
	addVector("div u by zero", 6'b110000, 64'h123456789ABCDEF0, 64'h0,
		64'hFFFFFFFFFFFFFFFF, 64'h123456789ABCDEF0);
	addVector("div u alt", 6'b110010, 64'h3e8, 64'h3, 64'h1, 64'h14d);
	// 32-bit mode, upper operand bits are don't care
	addVector("mul32 s neg*pos", 6'b000100, 64'hDEADBEEFFFFFFFFD, 64'h5,
		64'hFFFFFFFFFFFFFFF1, 64'hFFFFFFFFFFFFFFFF);
	addVector("mul32 u all ones", 6'b010100, 64'h12345678FFFFFFFF, 64'hFFFFFFFF,
		64'h1, 64'hFFFFFFFE);
	addVector("mul32 s neg*neg", 6'b000100, 64'hFFFFFFF8, 64'hFFFFFFFA, 64'h30, 64'h0);
	addVector("mul32 su neg*big", 6'b001100, 64'hFFFFFFFF, 64'h80000000,
		64'hFFFFFFFF80000000, 64'hFFFFFFFFFFFFFFFF);
	addVector("div32 s neg/pos", 6'b100100, 64'hFFFFFF9C, 64'h7,
		64'hFFFFFFFFFFFFFFF2, 64'hFFFFFFFFFFFFFFFE);
	addVector("div32 u alt", 6'b110110, 64'hFFFFFFFF, 64'hABCD000000000010,
		64'hf, 64'hFFFFFFF);
	// bypassed, results stay from the row above
	addVector("bypass mul", 6'b010001, 64'h9, 64'h9, 64'hf, 64'hFFFFFFF);
endfunction

//--- test/slowMulDivTb.sv
`timescale 1ns/1ns
`default_nettype none

module slowMulDivTb
	import mulDivPkg::*;
();

	localparam int ResetCycles = 4;
	localparam int RandomCount = 4;
	// longest run is 67 hold cycles plus idle and cooldown
	localparam int CyclesPerCommand = 75;

	// flags are isDiv isUnsigned unsignedB is32 wantAlt bypass
	typedef struct {
		string name;
		logic [5:0] flags;
		logic [DataWidth-1:0] a;
		logic [DataWidth-1:0] b;
		logic [DataWidth-1:0] expLo;
		logic [DataWidth-1:0] expHi;
	} vectorEntry;

	logic clock = 1'b0;
	logic reset;
	mulDivOp op;
	logic bypass;
	logic [DataWidth-1:0] valueA;
	logic [DataWidth-1:0] valueB;
	logic hold;
	logic [DataWidth-1:0] resultLo;
	logic [DataWidth-1:0] resultHi;

	vectorEntry vectors[$];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	integer seed;

	slowMulDiv dut_i (
		.clock(clock),
		.reset(reset),
		.op(op),
		.bypass(bypass),
		.valueA(valueA),
		.valueB(valueB),
		.hold(hold),
		.resultLo(resultLo),
		.resultHi(resultHi)
	);

	always #20 clock = ~clock;

	// stops a hung run
	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("checks: %0d, errors: %0d", checkCount, errorCount);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic void addVector(input string name, input logic [5:0] flags,
		input logic [DataWidth-1:0] a, input logic [DataWidth-1:0] b,
		input logic [DataWidth-1:0] expLo, input logic [DataWidth-1:0] expHi);
		vectorEntry entry;
		entry.name = name;
		entry.flags = flags;
		entry.a = a;
		entry.b = b;
		entry.expLo = expLo;
		entry.expHi = expHi;
		vectors.push_back(entry);
	endfunction

	`include "mulDivVectors.svh"

	// stall length per operation, none when bypassed
	function automatic int expectedHold(input logic [5:0] flags);
		if (flags[0])
			return 0;
		if (flags[5])
			return flags[2] ? int'(DivCycles32) : int'(DivCycles64);
		return flags[2] ? int'(MulCycles32) : int'(MulCycles64);
	endfunction

	task automatic checkValue(input string testName, input string what,
		input logic [DataWidth-1:0] expected, input logic [DataWidth-1:0] actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			$display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
			errorCount++;
		end
	endtask

	// valid for exactly one cycle
	task automatic issueCommand(input logic [5:0] flags, input logic [DataWidth-1:0] a,
		input logic [DataWidth-1:0] b);
		@(posedge clock);
		op.valid <= 1'b1;
		op.isDiv <= flags[5];
		op.isUnsigned <= flags[4];
		op.unsignedB <= flags[3];
		op.is32 <= flags[2];
		op.wantAlt <= flags[1];
		bypass <= flags[0];
		valueA <= a;
		valueB <= b;
		@(posedge clock);
		op.valid <= 1'b0;
		bypass <= 1'b0;
	endtask

	// hold low, then past the cooldown cycle
	task automatic waitIdle();
		@(negedge clock);
		while (hold)
			@(negedge clock);
		repeat (2)
			@(negedge clock);
	endtask

	// returns at the first negedge with hold low, results valid there
	task automatic countHold(output int cycles);
		cycles = 0;
		@(negedge clock);
		while (hold)
		begin
			cycles++;
			@(negedge clock);
		end
	endtask

	task automatic applyVector(input vectorEntry entry);
		int cycles;
		waitIdle();
		issueCommand(entry.flags, entry.a, entry.b);
		countHold(cycles);
		checkValue(entry.name, "hold cycles", DataWidth'(expectedHold(entry.flags)),
			DataWidth'(cycles));
		checkValue(entry.name, "resultLo", entry.expLo, resultLo);
		checkValue(entry.name, "resultHi", entry.expHi, resultHi);
	endtask

	// unsigned 64-bit multiply against a wide product
	task automatic randomMultiply(input int index);
		vectorEntry entry;
		logic [2*DataWidth-1:0] product;
		entry.name = $sformatf("mul u random %0d", index);
		entry.flags = 6'b010000;
		entry.a = {$random(seed), $random(seed)};
		entry.b = {$random(seed), $random(seed)};
		product = {{DataWidth{1'b0}}, entry.a} * {{DataWidth{1'b0}}, entry.b};
		entry.expLo = product[DataWidth-1:0];
		entry.expHi = product[2*DataWidth-1:DataWidth];
		applyVector(entry);
	endtask

	// second command arrives mid-run and must be dropped
	task automatic busyIgnoreTest();
		int cycles;
		waitIdle();
		issueCommand(6'b010000, 64'h6, 64'h7);
		repeat (5)
			@(posedge clock);
		issueCommand(6'b010000, 64'h64, 64'h64);
		countHold(cycles);
		// seven edges of the run went by before counting
		checkValue("busy ignore", "hold cycles", DataWidth'(int'(MulCycles64) - 7),
			DataWidth'(cycles));
		checkValue("busy ignore", "resultLo", 64'h2a, resultLo);
		checkValue("busy ignore", "resultHi", 64'h0, resultHi);
		repeat (4)
		begin
			@(negedge clock);
			checkCount++;
			assert (!hold)
			else
			begin
				$display("busy ignore: a command offered while busy started another run");
				errorCount++;
			end
		end
	endtask

	initial
	begin
		reset <= 1'b1;
		op <= '0;
		bypass <= 1'b0;
		valueA <= '0;
		valueB <= '0;
		seed = 47072;
		loadVectors();
		// one slot per command, busy test included
		cycleLimit = (vectors.size() + RandomCount + 1) * CyclesPerCommand + 50;

		repeat (ResetCycles)
			@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkValue("reset", "hold", 64'h0, DataWidth'(hold));
		checkValue("reset", "resultLo", 64'h0, resultLo);
		checkValue("reset", "resultHi", 64'h0, resultHi);

		foreach (vectors[i])
			applyVector(vectors[i]);
		for (int i = 0; i < RandomCount; i++)
			randomMultiply(i);
		busyIgnoreTest();

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/slowMulDiv.sv
`timescale 1ns/1ns
`default_nettype none

module slowMulDiv
	import mulDivPkg::*;
(
	input wire clock,
	input wire reset,
	input wire mulDivOp op,
	// command already handled elsewhere
	input wire bypass,
	input wire [DataWidth-1:0] valueA,
	input wire [DataWidth-1:0] valueB,
	// pipeline stall while iterating
	output logic hold,
	output logic [DataWidth-1:0] resultLo,
	output logic [DataWidth-1:0] resultHi
);

	// combinational setup from decode
	mulDivSetup setup;
	// iteration result, valid with raw.done
	mulDivRaw raw;

	// signs, magnitudes, addend and count
	mulDivOperandPrep prep_i (
		.op(op),
		.bypass(bypass),
		.valueA(valueA),
		.valueB(valueB),
		.setup(setup)
	);

	// acceptance, cooldown and the shift-add loop
	mulDivIterator iter_i (
		.clock(clock),
		.reset(reset),
		.setup(setup),
		.hold(hold),
		.raw(raw)
	);

	// sign fix, 32-bit extension and result registers
	// results land in the first cycle with hold low
	mulDivResultFix fix_i (
		.clock(clock),
		.reset(reset),
		.raw(raw),
		.resultLo(resultLo),
		.resultHi(resultHi)
	);

endmodule

`default_nettype wire

//--- design/mulDivResultFix.sv
`timescale 1ns/1ns
`default_nettype none

module mulDivResultFix
	import mulDivPkg::*;
(
	input wire clock,
	input wire reset,
	input wire mulDivRaw raw,
	output logic [DataWidth-1:0] resultLo,
	output logic [DataWidth-1:0] resultHi
);

	// full signed product
	logic [2*DataWidth-1:0] product;
	logic [DataWidth-1:0] quotient;
	logic [DataWidth-1:0] remainder;
	// sign of a nonzero result or zero when unsigned
	logic lowNeg;
	logic remNeg;
	logic [DataWidth-1:0] quotExt;
	logic [DataWidth-1:0] remExt;
	logic [DataWidth-1:0] nextLo;
	logic [DataWidth-1:0] nextHi;

	always_comb
	begin
		product = raw.negResult ? -{raw.accHigh, raw.accLow} : {raw.accHigh, raw.accLow};
		quotient = raw.negResult ? -raw.accLow : raw.accLow;
		remainder = raw.negRem ? -raw.accHigh : raw.accHigh;

		// a zero magnitude stays positive
		// accLow is the 32-bit product magnitude as well as the quotient
		lowNeg = raw.negResult && (raw.accLow != '0);
		remNeg = raw.negRem && (raw.accHigh != '0);

		quotExt = raw.is32 ? {{HalfWidth{lowNeg}}, quotient[HalfWidth-1:0]} : quotient;
		remExt = raw.is32 ? {{HalfWidth{remNeg}}, remainder[HalfWidth-1:0]} : remainder;

		if (raw.isDiv)
		begin
			nextLo = raw.wantAlt ? remExt : quotExt;
			nextHi = raw.wantAlt ? quotExt : remExt;
		end
		else if (raw.is32)
		begin
			// 64-bit product split into two extended words
			nextLo = {{HalfWidth{lowNeg}}, product[HalfWidth-1:0]};
			nextHi = {{HalfWidth{lowNeg}}, product[DataWidth-1:HalfWidth]};
		end
		else
		begin
			nextLo = product[DataWidth-1:0];
			nextHi = product[2*DataWidth-1:DataWidth];
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			resultLo <= '0;
			resultHi <= '0;
		end
		else if (raw.done)
		begin
			resultLo <= nextLo;
			resultHi <= nextHi;
		end
	end

	// one done pulse per command so the results are written once
	donePulseA: assert property (@(posedge clock) disable iff (reset)
		raw.done |=> !raw.done);

endmodule

`default_nettype wire

//--- design/mulDivIterator.sv
`timescale 1ns/1ns
`default_nettype none

module mulDivIterator
	import mulDivPkg::*;
(
	input wire clock,
	input wire reset,
	input wire mulDivSetup setup,
	output logic hold,
	output mulDivRaw raw
);

	// accumulator holds the low product or the partial remainder
	logic [DataWidth-1:0] acc;
	// multiplier or dividend bits leave the top, product or quotient bits enter the bottom
	logic [DataWidth-1:0] shiftReg;
	logic [DataWidth-1:0] addend;
	logic addCarry;
	logic [CountWidth-1:0] count;
	logic busy;
	// high for the one cycle after busy drops
	logic cooldown;
	logic isDiv;
	logic is32;
	logic wantAlt;
	logic negResult;
	logic negRem;

	logic accept;
	logic stepping;
	logic [CountWidth-1:0] tail;
	logic multBit;
	logic [DataWidth-1:0] accShifted;
	logic [DataWidth-1:0] sum;
	logic carryOut;
	logic keepSub;
	logic useSum;
	logic [DataWidth-1:0] shiftBase;
	logic [DataWidth-1:0] accNext;
	logic [DataWidth-1:0] shiftNext;

	// commands while busy or in cooldown are dropped
	assign accept = setup.start && !busy && !cooldown;
	// steps stop once only the tail is left
	assign tail = isDiv ? DivTail : MulTail;
	assign stepping = busy && (count > tail);

	assign multBit = shiftReg[DataWidth-1];
	// divide pulls the next dividend bit into the remainder
	assign accShifted = {acc[DataWidth-2:0], isDiv && shiftReg[DataWidth-1]};

	carrySelectAdder64 adder_i (
		.a(accShifted),
		.b(addend),
		.carryIn(addCarry),
		.sum(sum),
		.carryOut(carryOut)
	);

	// no borrow, or a bit fell off the top so the remainder is surely larger
	assign keepSub = carryOut || acc[DataWidth-1];
	assign useSum = isDiv ? keepSub : multBit;
	assign accNext = useSum ? sum : accShifted;
	// multiply moves the acc top bit into the high product, divide the quotient bit
	assign shiftBase = {shiftReg[DataWidth-2:0], isDiv ? keepSub : acc[DataWidth-1]};
	// low product carry, never reaches the remaining multiplier bits
	assign shiftNext = shiftBase + {{(DataWidth-1){1'b0}}, !isDiv && multBit && carryOut};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count <= '0;
			busy <= 1'b0;
			cooldown <= 1'b0;
		end
		else
		begin
			cooldown <= busy;
			if (accept)
			begin
				count <= setup.count;
				busy <= 1'b1;
			end
			else if (busy)
			begin
				count <= count - CountWidth'(1);
				busy <= (count != CountWidth'(1));
			end
		end
	end

	// datapath and command copy
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			acc <= '0;
			shiftReg <= setup.shiftInit;
			addend <= setup.addend;
			addCarry <= setup.addCarry;
			isDiv <= setup.isDiv;
			is32 <= setup.is32;
			wantAlt <= setup.wantAlt;
			negResult <= setup.negResult;
			negRem <= setup.negRem;
		end
		else if (stepping)
		begin
			acc <= accNext;
			shiftReg <= shiftNext;
		end
	end

	assign hold = busy;

	always_comb
	begin
		// last hold cycle, state has been settled since the tail began
		raw.done = busy && (count == CountWidth'(1));
		raw.isDiv = isDiv;
		raw.is32 = is32;
		raw.wantAlt = wantAlt;
		raw.negResult = negResult;
		raw.negRem = negRem;
		// registers swap roles between multiply and divide
		raw.accHigh = isDiv ? acc : shiftReg;
		raw.accLow = isDiv ? shiftReg : acc;
	end

	// busy and counter are updated in separate branches
	busyCountA: assert property (@(posedge clock) disable iff (reset)
		busy |-> (count != '0));

	// a new setup must not reach a running command
	stableCmdA: assert property (@(posedge clock) disable iff (reset)
		busy |=> $stable({addend, addCarry, isDiv, is32, wantAlt, negResult, negRem}));

endmodule

`default_nettype wire

//--- design/mulDivOperandPrep.sv
`timescale 1ns/1ns
`default_nettype none

module mulDivOperandPrep
	import mulDivPkg::*;
(
	input wire mulDivOp op,
	input wire bypass,
	input wire [DataWidth-1:0] valueA,
	input wire [DataWidth-1:0] valueB,
	output mulDivSetup setup
);

	logic signA;
	logic signB;
	// magnitudes before placement
	logic [DataWidth-1:0] absA;
	logic [DataWidth-1:0] absB;
	// magnitudes as the iterator wants them
	logic [DataWidth-1:0] placedA;
	logic [DataWidth-1:0] placedB;
	logic [CountWidth-1:0] cycleCount;

	always_comb
	begin
		// sign bit depends on mode
		signA = op.is32 ? valueA[HalfWidth-1] : valueA[DataWidth-1];
		signB = op.is32 ? valueB[HalfWidth-1] : valueB[DataWidth-1];
		if (op.isUnsigned)
		begin
			signA = 1'b0;
			signB = 1'b0;
		end
		// mixed signedness, B taken as unsigned
		if (op.unsignedB)
			signB = 1'b0;

		// most negative value gives 2^63, still fine as unsigned
		absA = signA ? -valueA : valueA;
		absB = signB ? -valueB : valueB;

		// 32-bit mode, A moves up so its top bit leaves first
		placedA = absA;
		placedB = absB;
		if (op.is32)
		begin
			placedA = {absA[HalfWidth-1:0], {HalfWidth{1'b0}}};
			placedB = {{HalfWidth{1'b0}}, absB[HalfWidth-1:0]};
		end
	end

	always_comb
	begin
		case ({op.isDiv, op.is32})
			2'b00: cycleCount = MulCycles64;
			2'b01: cycleCount = MulCycles32;
			2'b10: cycleCount = DivCycles64;
			default: cycleCount = DivCycles32;
		endcase
	end

	always_comb
	begin
		// iterator decides whether it actually takes this
		setup.start = op.valid && !bypass;
		setup.isDiv = op.isDiv;
		setup.is32 = op.is32;
		setup.wantAlt = op.wantAlt;
		setup.negResult = signA ^ signB;
		setup.negRem = signA;
		setup.shiftInit = placedA;
		// divide subtracts, so ~B with carry in completes -B
		setup.addend = op.isDiv ? ~placedB : placedB;
		setup.addCarry = op.isDiv;
		setup.count = cycleCount;
	end

endmodule

`default_nettype wire

//--- design/carrySelectAdder64.sv
`timescale 1ns/1ns
`default_nettype none

module carrySelectAdder64
	import mulDivPkg::*;
(
	input wire [DataWidth-1:0] a,
	input wire [DataWidth-1:0] b,
	input wire carryIn,
	output logic [DataWidth-1:0] sum,
	output logic carryOut
);

	// carry into each slice, last entry is the carry out
	logic [SliceCount:0] sliceCarry;

	assign sliceCarry[0] = carryIn;

	for (genvar i = 0; i < SliceCount; i++)
	begin : gSlice
		// both outcomes, with the slice carry out in the top bit
		logic [SliceWidth:0] sumC0;
		logic [SliceWidth:0] sumC1;
		logic [SliceWidth-1:0] sliceA;
		logic [SliceWidth-1:0] sliceB;

		assign sliceA = a[i*SliceWidth +: SliceWidth];
		assign sliceB = b[i*SliceWidth +: SliceWidth];

		// slice adds run in parallel
		assign sumC0 = {1'b0, sliceA} + {1'b0, sliceB};
		assign sumC1 = {1'b0, sliceA} + {1'b0, sliceB} + {{SliceWidth{1'b0}}, 1'b1};

		// only the select chain is serial
		assign sum[i*SliceWidth +: SliceWidth] = sliceCarry[i] ?
			sumC1[SliceWidth-1:0] : sumC0[SliceWidth-1:0];
		assign sliceCarry[i+1] = sliceCarry[i] ? sumC1[SliceWidth] : sumC0[SliceWidth];
	end

	assign carryOut = sliceCarry[SliceCount];

endmodule

`default_nettype wire

//--- design/mulDivPkg.sv
`default_nettype none

package mulDivPkg;

	// operand and result width
	localparam int DataWidth = 64;
	// operand width in 32-bit mode
	localparam int HalfWidth = 32;

	// carry-select slices of the iteration adder
	localparam int SliceWidth = 16;
	localparam int SliceCount = DataWidth / SliceWidth;

	// cycle counter, longest run is 67
	localparam int CountWidth = 7;

	// settled cycles at the end of a run, counter still running
	localparam logic [CountWidth-1:0] MulTail = CountWidth'(2);
	localparam logic [CountWidth-1:0] DivTail = CountWidth'(3);

	// hold length per operation, one step per data bit plus the tail
	localparam logic [CountWidth-1:0] MulCycles64 = CountWidth'(DataWidth) + MulTail;
	localparam logic [CountWidth-1:0] MulCycles32 = CountWidth'(HalfWidth) + MulTail;
	localparam logic [CountWidth-1:0] DivCycles64 = CountWidth'(DataWidth) + DivTail;
	localparam logic [CountWidth-1:0] DivCycles32 = CountWidth'(HalfWidth) + DivTail;

	// operation word from decode
	typedef struct packed {
		logic valid;
		logic isDiv;
		// both operands unsigned
		logic isUnsigned;
		// signed A times unsigned B
		logic unsignedB;
		logic is32;
		// divide only, remainder to the low result
		logic wantAlt;
	} mulDivOp;

	// command as set up by operand prep, latched on start
	typedef struct packed {
		logic start;
		logic isDiv;
		logic is32;
		logic wantAlt;
		logic negResult;
		// remainder follows the dividend
		logic negRem;
		// magnitude of A, upper half in 32-bit mode
		logic [DataWidth-1:0] shiftInit;
		// |B| for multiply, ~|B| for divide
		logic [DataWidth-1:0] addend;
		logic addCarry;
		logic [CountWidth-1:0] count;
	} mulDivSetup;

	// unsigned iteration result plus what fixup needs
	typedef struct packed {
		// last hold cycle
		logic done;
		logic isDiv;
		logic is32;
		logic wantAlt;
		logic negResult;
		logic negRem;
		// remainder or high product
		logic [DataWidth-1:0] accHigh;
		// quotient or low product
		logic [DataWidth-1:0] accLow;
	} mulDivRaw;

endpackage

`default_nettype wire
